/* core_monitor.f */
source/monitor_cfg_pkg.sv
source/monitor_probe_pkg.sv
source/mepc_tracker.sv
source/step_monitor.sv
source/priv_monitor.sv
source/bus_attr_checker.sv
source/core_monitor_top.sv
testbench/tb_core_monitor.sv

/* run_sim.sh */
#!/bin/sh
# Build the core monitor testbench with Verilator, run it and scan the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_core_monitor -f core_monitor.f -o sim_core_monitor

./obj_dir/sim_core_monitor | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"

/* source/bus_attr_checker.sv */
// OBI attribute checker for instruction and data requests.
// Fetches and loads must be non-bufferable. Atomics must be absent when
// the A extension is off, and non-bufferable when it is on.

`timescale 1ns/1ps
`default_nettype none

module bus_attr_checker #(
  parameter bit ATOMICS_EN = 1'b0
) (
  input  logic                          clk,
  input  logic                          rst_ni,
  input  monitor_probe_pkg::bus_probe_t bus_i,
  output logic                          bus_attr_o
);

  localparam int unsigned BUF = monitor_cfg_pkg::MEMTYPE_BUFFERABLE_BIT;

  logic fetch_bad;
  logic load_bad;
  logic atop_bad;

  // The fetch attribute is checked every cycle, as in the core's OBI port
  assign fetch_bad = bus_i.instr_memtype[BUF];
  assign load_bad  = bus_i.data_req && !bus_i.data_we && bus_i.data_memtype[BUF];

  if (ATOMICS_EN) begin : g_atomics
    // Atomic requests may not be merged or buffered
    assign atop_bad = bus_i.data_req && (|bus_i.data_atop) && bus_i.data_memtype[BUF];
  end else begin : g_no_atomics
    // Without the A extension the atop lines stay at zero
    assign atop_bad = |bus_i.data_atop;
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_attr_o <= 1'b0;
    end else begin
      bus_attr_o <= fetch_bad || load_bad || atop_bad;
    end
  end

endmodule

`default_nettype wire

/* source/core_monitor_top.sv */
// Top level of the core run-time monitor.
// Takes the probed core signals as five structs, hands each checker the
// part it needs and gathers the registered flags into one violation
// vector. Every flag trails its offending sample by one cycle.

`timescale 1ns/1ps
`default_nettype none

module core_monitor_top #(
  parameter bit ATOMICS_EN = 1'b0
) (
  input  logic                           clk,
  input  logic                           rst_ni,
  input  monitor_probe_pkg::wb_probe_t   wb_i,
  input  monitor_probe_pkg::trap_save_t  trap_i,
  input  monitor_probe_pkg::ctrl_probe_t ctrl_i,
  input  monitor_probe_pkg::priv_probe_t priv_i,
  input  monitor_probe_pkg::bus_probe_t  bus_i,
  output monitor_probe_pkg::violation_t  violation_o
);

  logic       mepc_mismatch;
  logic       step_retire;
  logic [4:0] priv_flags;
  logic       bus_attr;

  mepc_tracker u_mepc_tracker (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .wb_i            (wb_i),
    .trap_i          (trap_i),
    .mepc_mismatch_o (mepc_mismatch)
  );

  // Stepping is judged on write-back retires against the controller state
  step_monitor u_step_monitor (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .wb_valid_i    (wb_i.valid),
    .debug_mode_i  (ctrl_i.debug_mode),
    .step_i        (ctrl_i.step),
    .step_retire_o (step_retire)
  );

  priv_monitor u_priv_monitor (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .priv_i       (priv_i),
    .ctrl_i       (ctrl_i),
    .priv_flags_o (priv_flags)
  );

  bus_attr_checker #(
    .ATOMICS_EN (ATOMICS_EN)
  ) u_bus_attr_checker (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .bus_i      (bus_i),
    .bus_attr_o (bus_attr)
  );

  // The priv flags arrive in the same order as their struct fields
  assign violation_o = {mepc_mismatch, step_retire, priv_flags, bus_attr};

endmodule

`default_nettype wire

/* source/mepc_tracker.sv */
// Trap PC checker for the four tracked exception classes.
// The first retiring instruction of each class gives the expected trap PC,
// the first matching trap save gives the actual one. A mismatch on that
// first save is flagged one cycle later; later events of a class are ignored.

`timescale 1ns/1ps
`default_nettype none

module mepc_tracker (
  input  logic                          clk,
  input  logic                          rst_ni,
  input  monitor_probe_pkg::wb_probe_t  wb_i,
  input  monitor_probe_pkg::trap_save_t trap_i,
  output logic                          mepc_mismatch_o
);

  localparam int unsigned NC = monitor_cfg_pkg::NUM_EXC_CLASSES;

  // Cause code that the CSR file records for a given class
  function automatic monitor_cfg_pkg::exc_code_t class_code(input logic [1:0] idx);
    monitor_cfg_pkg::exc_code_t code;
    case (monitor_cfg_pkg::exc_class_e'(idx))
      monitor_cfg_pkg::EXC_CLASS_BUS_FAULT: code = monitor_cfg_pkg::EXC_INSTR_BUS_FAULT;
      monitor_cfg_pkg::EXC_CLASS_ILLEGAL:   code = monitor_cfg_pkg::EXC_ILLEGAL;
      monitor_cfg_pkg::EXC_CLASS_ECALL:     code = monitor_cfg_pkg::EXC_ECALL_M;
      default:                              code = monitor_cfg_pkg::EXC_BREAKPOINT;
    endcase
    return code;
  endfunction

  logic                   retire;
  logic [NC-1:0]          exp_hit;
  logic [NC-1:0]          exp_found_q;
  logic [NC-1:0]          act_first;
  logic [NC-1:0]          act_found_q;
  logic [NC-1:0]          cmp_fail;
  monitor_cfg_pkg::xlen_t exp_pc_q [NC];

  ////////////////////////////////////////////////////////////
  // Expected side
  ////////////////////////////////////////////////////////////

  // Several exception bits can be set at once, so only the one with the
  // highest priority decides the class of a retiring instruction
  always_comb begin
    retire  = wb_i.valid && !wb_i.debug_mode_next;
    exp_hit = '0;
    exp_hit[monitor_cfg_pkg::EXC_CLASS_BUS_FAULT] = retire && wb_i.bus_err;
    exp_hit[monitor_cfg_pkg::EXC_CLASS_ILLEGAL]   = retire && !wb_i.bus_err && wb_i.illegal;
    exp_hit[monitor_cfg_pkg::EXC_CLASS_ECALL]     = retire && !wb_i.bus_err && !wb_i.illegal &&
                                                    wb_i.ecall;
    exp_hit[monitor_cfg_pkg::EXC_CLASS_EBREAK]    = retire && !wb_i.bus_err && !wb_i.illegal &&
                                                    !wb_i.ecall && wb_i.ebreak;
  end

  // Captured PCs, written once per class
  always_ff @(posedge clk) begin
    for (int c = 0; c < NC; c++) begin
      if (exp_hit[c] && !exp_found_q[c]) begin
        exp_pc_q[c] <= wb_i.pc;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Actual side and comparison
  ////////////////////////////////////////////////////////////

  always_comb begin : cmp_comb
    monitor_cfg_pkg::xlen_t exp_pc;
    logic                   exp_known;
    for (int c = 0; c < NC; c++) begin
      // Saves caused by interrupts never count toward an exception class
      act_first[c] = trap_i.save && !trap_i.interrupt && !act_found_q[c] &&
                     (trap_i.exc_code == class_code(2'(c)));
      // A capture in the same cycle as the first save still counts
      exp_known   = exp_found_q[c] || exp_hit[c];
      exp_pc      = exp_found_q[c] ? exp_pc_q[c] : wb_i.pc;
      cmp_fail[c] = act_first[c] && exp_known && (exp_pc != trap_i.mepc_next);
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_found_q     <= '0;
      act_found_q     <= '0;
      mepc_mismatch_o <= 1'b0;
    end else begin
      exp_found_q     <= exp_found_q | exp_hit;
      act_found_q     <= act_found_q | act_first;
      mepc_mismatch_o <= |cmp_fail;
    end
  end

  // Interrupt saves carry a valid cause code, never an unknown one
  a_irq_code_range : assert property (@(posedge clk) disable iff (!rst_ni)
    (trap_i.save && trap_i.interrupt) |->
      (!$isunknown(trap_i.exc_code) && (int'(trap_i.exc_code) inside {[0:31]})))
    else $error("Interrupt trap save with exception code outside 0 to 31");

endmodule

`default_nettype wire

/* source/monitor_cfg_pkg.sv */
// Configuration and encodings shared by the core run-time monitor.
// Holds the meaningful widths, the privilege levels, the next-PC sources
// and the exception cause codes that the checkers decode.
// Other files refer to these by scoped names.

`default_nettype none

package monitor_cfg_pkg;

  // Machine word, used for the PC and the saved trap PC
  typedef logic [31:0] xlen_t;
  // Exception cause code as written to the cause CSR
  typedef logic [4:0]  exc_code_t;
  // OBI memory type, bit 0 marks a bufferable access
  typedef logic [1:0]  memtype_t;
  // Atomic operation code on the data bus, zero means a plain access
  typedef logic [5:0]  atop_t;

  localparam int unsigned MEMTYPE_BUFFERABLE_BIT = 0;

  // Only user and machine mode exist on this core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Source of the next fetch address when the controller sets the PC
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5,
    PC_TRAP_DBG = 3'd6,
    PC_TRAP_NMI = 3'd7
  } pc_mux_e;

  localparam exc_code_t EXC_INSTR_BUS_FAULT = 5'h01;
  localparam exc_code_t EXC_ILLEGAL         = 5'h02;
  localparam exc_code_t EXC_BREAKPOINT      = 5'h03;
  localparam exc_code_t EXC_ECALL_M         = 5'h0b;

  localparam int unsigned NUM_EXC_CLASSES = 4;

  // Tracked exception classes, listed from highest to lowest priority
  typedef enum logic [1:0] {
    EXC_CLASS_BUS_FAULT = 2'd0,
    EXC_CLASS_ILLEGAL   = 2'd1,
    EXC_CLASS_ECALL     = 2'd2,
    EXC_CLASS_EBREAK    = 2'd3
  } exc_class_e;

endpackage

`default_nettype wire

/* source/monitor_probe_pkg.sv */
// Probe and result structs for the core run-time monitor.
// Each struct groups the core signals sampled by one part of the monitor.
// The violation vector is the single result of the top level.

`default_nettype none

package monitor_probe_pkg;

  // Write-back stage view of the retiring instruction
  typedef struct packed {
    logic                      valid;
    monitor_cfg_pkg::xlen_t    pc;
    logic                      illegal;
    logic                      ecall;
    logic                      ebreak;
    logic                      bus_err;
    // Debug mode as it will be in the next cycle
    logic                      debug_mode_next;
  } wb_probe_t;

  // Cause and trap PC handed to the CSR file when a trap is taken
  typedef struct packed {
    logic                       save;
    logic                       interrupt;
    monitor_cfg_pkg::exc_code_t exc_code;
    monitor_cfg_pkg::xlen_t     mepc_next;
  } trap_save_t;

  // Controller outputs that steer fetch, plus the debug step bit
  typedef struct packed {
    logic                     pc_set;
    monitor_cfg_pkg::pc_mux_e pc_mux;
    logic                     kill_if;
    logic                     debug_mode;
    logic                     step;
  } ctrl_probe_t;

  // Privilege state across the pipeline and the MRET location
  typedef struct packed {
    monitor_cfg_pkg::priv_lvl_e priv_lvl;
    monitor_cfg_pkg::priv_lvl_e priv_lvl_if;
    logic                       mret_id;
    logic                       mret_ex;
    logic                       mret_wb;
    logic                       if_valid_id;
    monitor_cfg_pkg::priv_lvl_e mpp;
  } priv_probe_t;

  // Instruction and data OBI attributes
  typedef struct packed {
    monitor_cfg_pkg::memtype_t instr_memtype;
    logic                      data_req;
    logic                      data_we;
    monitor_cfg_pkg::memtype_t data_memtype;
    monitor_cfg_pkg::atop_t    data_atop;
  } bus_probe_t;

  // One flag per rule, MSB first; the five priv flags are contiguous
  typedef struct packed {
    logic mepc_mismatch;
    logic step_retire;
    logic priv_consistency;
    logic priv_to_user;
    logic priv_to_machine;
    logic trap_not_machine;
    logic mret_priv;
    logic bus_attr;
  } violation_t;

endpackage

`default_nettype wire

/* source/priv_monitor.sv */
// Privilege-level checker for the fetch side of the pipeline.
// Keeps last cycle's IF privilege level and tests five transition and
// consistency rules. The flags leave as a 5-bit vector in the order of
// the priv fields of the violation struct, MSB first.

`timescale 1ns/1ps
`default_nettype none

module priv_monitor (
  input  logic                           clk,
  input  logic                           rst_ni,
  input  monitor_probe_pkg::priv_probe_t priv_i,
  input  monitor_probe_pkg::ctrl_probe_t ctrl_i,
  output logic [4:0]                     priv_flags_o
);

  monitor_cfg_pkg::priv_lvl_e priv_lvl_if_q;
  logic                       hist_valid_q;
  logic                       pc_mux_is_trap;
  logic                       lvl_changed;
  logic                       mret_in_pipe;
  logic [4:0]                 flags_d;

  // All four trap sources count, including debug entry and NMI
  assign pc_mux_is_trap = ctrl_i.pc_mux inside {monitor_cfg_pkg::PC_TRAP_EXC,
                                                monitor_cfg_pkg::PC_TRAP_IRQ,
                                                monitor_cfg_pkg::PC_TRAP_DBG,
                                                monitor_cfg_pkg::PC_TRAP_NMI};

  // History is meaningless in the first cycle out of reset
  assign lvl_changed  = hist_valid_q && (priv_i.priv_lvl_if != priv_lvl_if_q);
  assign mret_in_pipe = priv_i.mret_id || priv_i.mret_ex || priv_i.mret_wb;

  ////////////////////////////////////////////////////////////
  // Rules
  ////////////////////////////////////////////////////////////

  always_comb begin
    // MRET in ID moves the IF level ahead of priv_lvl until it retires
    flags_d[4] = hist_valid_q && (priv_lvl_if_q != priv_i.priv_lvl) && !mret_in_pipe;
    // Dropping to user mode is only done by an MRET in ID with mpp = U
    flags_d[3] = lvl_changed && (priv_i.priv_lvl_if == monitor_cfg_pkg::PRIV_LVL_U) &&
                 !(priv_i.mret_id && priv_i.if_valid_id &&
                   (priv_i.mpp == monitor_cfg_pkg::PRIV_LVL_U));
    // Raising to machine mode needs a trap, or a killed IF that restores M
    flags_d[2] = lvl_changed && (priv_i.priv_lvl_if == monitor_cfg_pkg::PRIV_LVL_M) &&
                 !((ctrl_i.pc_set && pc_mux_is_trap) || ctrl_i.kill_if);
    // Traps outside debug always fetch the handler in machine mode
    flags_d[1] = ctrl_i.pc_set && pc_mux_is_trap && !ctrl_i.debug_mode &&
                 (priv_i.priv_lvl_if != monitor_cfg_pkg::PRIV_LVL_M);
    // Jump to mepc fetches with the level held in mstatus.mpp
    flags_d[0] = ctrl_i.pc_set && (ctrl_i.pc_mux == monitor_cfg_pkg::PC_MRET) &&
                 (priv_i.priv_lvl_if != priv_i.mpp);
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_lvl_if_q <= monitor_cfg_pkg::PRIV_LVL_M;
      hist_valid_q  <= 1'b0;
      priv_flags_o  <= '0;
    end else begin
      priv_lvl_if_q <= priv_i.priv_lvl_if;
      hist_valid_q  <= 1'b1;
      priv_flags_o  <= flags_d;
    end
  end

  // The controller only ever selects a defined next-PC source
  a_pc_mux_defined : assert property (@(posedge clk) disable iff (!rst_ni)
    ctrl_i.pc_set |-> (!$isunknown(ctrl_i.pc_mux) &&
                       (ctrl_i.pc_mux inside {[monitor_cfg_pkg::PC_BOOT :
                                               monitor_cfg_pkg::PC_TRAP_NMI]})))
    else $error("PC set with an unused pc_mux encoding");

endmodule

`default_nettype wire

/* source/step_monitor.sv */
// Single-step retire checker.
// A retire while stepping outside debug arms the checker. The next retire
// must happen in debug mode with step still set, otherwise a second
// instruction slipped through and the flag rises one cycle later.

`timescale 1ns/1ps
`default_nettype none

module step_monitor (
  input  logic clk,
  input  logic rst_ni,
  input  logic wb_valid_i,
  input  logic debug_mode_i,
  input  logic step_i,
  output logic step_retire_o
);

  logic armed_q;
  logic armed_d;
  logic step_fail;

  always_comb begin
    armed_d = armed_q;
    // Each retire either re-arms or clears, so the rule restarts on
    // every stepped instruction
    if (wb_valid_i) begin
      armed_d = step_i && !debug_mode_i;
    end
  end

  // Second retire after a stepped one, but not from debug mode
  assign step_fail = wb_valid_i && armed_q && !(debug_mode_i && step_i);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q       <= 1'b0;
      step_retire_o <= 1'b0;
    end else begin
      armed_q       <= armed_d;
      step_retire_o <= step_fail;
    end
  end

  // A retire is only judged against known debug and step bits
  a_retire_inputs_known : assert property (@(posedge clk) disable iff (!rst_ni)
    wb_valid_i |-> !$isunknown({debug_mode_i, step_i}))
    else $error("Retire with an unknown debug mode or step bit");

endmodule

`default_nettype wire

/* testbench/tb_core_monitor.sv */
// Testbench for the core run-time monitor.
// Drives the five probe structs from a fixed-seed LFSR, predicts the violation
// vector with a behavioural model and compares it one cycle later.
// Phases cover reset, trap PC, single step, privilege, bus attributes and a
// combined random run. A watchdog bounds the run time.

`timescale 1ns/1ps
`default_nettype none

module tb_core_monitor;

  localparam bit ATOMICS_EN   = 1'b0;
  localparam int TRAP_ROUNDS  = 8;
  localparam int ROUND_CYCLES = 40;
  localparam int STEP_CYCLES  = 300;
  localparam int PRIV_CYCLES  = 400;
  localparam int BUS_CYCLES   = 200;
  localparam int MIX_CYCLES   = 2000;
  // Every reset takes 3 cycles and the directed privilege sequence takes 7
  localparam int TOTAL_CYCLES = 3 + TRAP_ROUNDS * (3 + ROUND_CYCLES) + STEP_CYCLES + 7 +
                                PRIV_CYCLES + BUS_CYCLES + 3 + MIX_CYCLES;
  localparam int WATCHDOG_NS  = TOTAL_CYCLES * 8 * 3 / 2;

  localparam monitor_cfg_pkg::priv_lvl_e LVL_U = monitor_cfg_pkg::PRIV_LVL_U;
  localparam monitor_cfg_pkg::priv_lvl_e LVL_M = monitor_cfg_pkg::PRIV_LVL_M;

  logic                           clk = 1'b0;
  logic                           rst_ni;
  monitor_probe_pkg::wb_probe_t   wb;
  monitor_probe_pkg::trap_save_t  trap;
  monitor_probe_pkg::ctrl_probe_t ctrl;
  monitor_probe_pkg::priv_probe_t priv;
  monitor_probe_pkg::bus_probe_t  bus;
  monitor_probe_pkg::violation_t  violation;
  monitor_probe_pkg::violation_t  exp_viol;
  logic [31:0]                    lfsr_state = 32'h2c3f_8c63;
  int                             check_count = 0;
  int                             err_count = 0;

  // Model state that mirrors what each rule has to remember
  logic [3:0]                 m_exp_found;
  logic [3:0]                 m_act_found;
  monitor_cfg_pkg::xlen_t     m_exp_pc [4];
  logic                       m_armed;
  logic                       m_hist;
  monitor_cfg_pkg::priv_lvl_e m_prev_if;

  core_monitor_top #(
    .ATOMICS_EN (ATOMICS_EN)
  ) u_core_monitor_top (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .wb_i        (wb),
    .trap_i      (trap),
    .ctrl_i      (ctrl),
    .priv_i      (priv),
    .bus_i       (bus),
    .violation_o (violation)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1 give a maximal-length sequence
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic rand_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic monitor_cfg_pkg::priv_lvl_e rand_lvl();
    return rand_bit() ? LVL_M : LVL_U;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Class of a retire outside debug, or -1 when it belongs to none
  function automatic int retire_class(input monitor_probe_pkg::wb_probe_t w);
    if (!w.valid || w.debug_mode_next) return -1;
    if (w.bus_err) return 0;
    if (w.illegal) return 1;
    if (w.ecall) return 2;
    if (w.ebreak) return 3;
    return -1;
  endfunction

  function automatic monitor_cfg_pkg::exc_code_t cause_of(input int c);
    case (c)
      0:       return monitor_cfg_pkg::EXC_INSTR_BUS_FAULT;
      1:       return monitor_cfg_pkg::EXC_ILLEGAL;
      2:       return monitor_cfg_pkg::EXC_ECALL_M;
      default: return monitor_cfg_pkg::EXC_BREAKPOINT;
    endcase
  endfunction

  task automatic model_reset();
    m_exp_found = '0;
    m_act_found = '0;
    m_armed     = 1'b0;
    m_hist      = 1'b0;
    m_prev_if   = LVL_M;
    exp_viol    = '0;
  endtask

  // Predicts the flags for the inputs now on the bus and advances the state
  task automatic model_step();
    int                            cls;
    logic                          chg;
    logic                          mret_any;
    logic                          is_trap;
    monitor_probe_pkg::violation_t v;
    v   = '0;
    cls = retire_class(wb);
    for (int c = 0; c < 4; c++) begin
      if (trap.save && !trap.interrupt && !m_act_found[c] &&
          (trap.exc_code == cause_of(c))) begin
        m_act_found[c] = 1'b1;
        if (m_exp_found[c] && (m_exp_pc[c] != trap.mepc_next)) v.mepc_mismatch = 1'b1;
        if (!m_exp_found[c] && (cls == c) && (wb.pc != trap.mepc_next)) v.mepc_mismatch = 1'b1;
      end
    end
    if (cls >= 0 && !m_exp_found[cls]) begin
      m_exp_found[cls] = 1'b1;
      m_exp_pc[cls]    = wb.pc;
    end
    // The retire after an armed one must come from debug with step still set
    v.step_retire = wb.valid && m_armed && !(ctrl.debug_mode && ctrl.step);
    if (wb.valid) begin
      m_armed = ctrl.step && !ctrl.debug_mode;
    end
    is_trap  = (ctrl.pc_mux == monitor_cfg_pkg::PC_TRAP_EXC) ||
               (ctrl.pc_mux == monitor_cfg_pkg::PC_TRAP_IRQ) ||
               (ctrl.pc_mux == monitor_cfg_pkg::PC_TRAP_DBG) ||
               (ctrl.pc_mux == monitor_cfg_pkg::PC_TRAP_NMI);
    mret_any = priv.mret_id || priv.mret_ex || priv.mret_wb;
    chg      = m_hist && (priv.priv_lvl_if != m_prev_if);
    v.priv_consistency = m_hist && (m_prev_if != priv.priv_lvl) && !mret_any;
    v.priv_to_user     = chg && (priv.priv_lvl_if == LVL_U) &&
                         !(priv.mret_id && priv.if_valid_id && (priv.mpp == LVL_U));
    v.priv_to_machine  = chg && (priv.priv_lvl_if == LVL_M) &&
                         !((ctrl.pc_set && is_trap) || ctrl.kill_if);
    v.trap_not_machine = ctrl.pc_set && is_trap && !ctrl.debug_mode &&
                         (priv.priv_lvl_if != LVL_M);
    v.mret_priv        = ctrl.pc_set && (ctrl.pc_mux == monitor_cfg_pkg::PC_MRET) &&
                         (priv.priv_lvl_if != priv.mpp);
    m_prev_if = priv.priv_lvl_if;
    m_hist    = 1'b1;
    v.bus_attr = bus.instr_memtype[0] || (bus.data_req && !bus.data_we && bus.data_memtype[0]) ||
                 (ATOMICS_EN ? (bus.data_req && (|bus.data_atop) && bus.data_memtype[0])
                             : (|bus.data_atop));
    exp_viol = v;
  endtask

  ////////////////////////////////////////////////////////////
  // Checks, stimulus and cycle control
  ////////////////////////////////////////////////////////////

  task automatic check_violation(input monitor_probe_pkg::violation_t got,
                                 input monitor_probe_pkg::violation_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] violation_o got 0x%02h expected 0x%02h at %0t ns", got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
    end
  endtask

  // Machine mode everywhere with no strobes and no requests
  task automatic drive_quiet();
    wb               = '0;
    trap             = '0;
    ctrl             = '0;
    priv             = '0;
    priv.priv_lvl    = LVL_M;
    priv.priv_lvl_if = LVL_M;
    priv.mpp         = LVL_M;
    bus              = '0;
  endtask

  task automatic rand_wb();
    wb.valid           = rand_bit();
    wb.pc              = rand_bits(30) << 2;
    wb.illegal         = (rand_bits(2) == 0);
    wb.ecall           = (rand_bits(2) == 0);
    wb.ebreak          = (rand_bits(2) == 0);
    wb.bus_err         = (rand_bits(2) == 0);
    wb.debug_mode_next = (rand_bits(3) == 0);
  endtask

  // Most saves point at the PC the model captured and some get one bit flipped
  task automatic rand_trap();
    int c;
    int cls;
    c              = int'(rand_bits(2));
    cls            = retire_class(wb);
    trap.save      = (rand_bits(2) == 0);
    trap.interrupt = (rand_bits(3) == 0);
    trap.exc_code  = (rand_bits(3) == 0) ? 5'(rand_bits(5)) : cause_of(c);
    trap.mepc_next = m_exp_found[c] ? m_exp_pc[c] : ((cls == c) ? wb.pc : (rand_bits(30) << 2));
    if (rand_bits(2) == 0) begin
      trap.mepc_next = trap.mepc_next ^ (32'h4 << rand_bits(3));
    end
  endtask

  task automatic rand_ctrl();
    ctrl.pc_set     = rand_bit();
    ctrl.pc_mux     = monitor_cfg_pkg::pc_mux_e'(3'(rand_bits(3)));
    ctrl.kill_if    = (rand_bits(2) == 0);
    ctrl.debug_mode = (rand_bits(3) == 0);
    ctrl.step       = rand_bit();
  endtask

  // priv_lvl mostly follows last cycle's IF level, which changes now and then
  task automatic rand_priv();
    priv.priv_lvl = (rand_bits(2) == 0) ? rand_lvl() : priv.priv_lvl_if;
    if (rand_bits(2) == 0) begin
      priv.priv_lvl_if = rand_lvl();
    end
    priv.mret_id     = (rand_bits(2) == 0);
    priv.mret_ex     = (rand_bits(2) == 0);
    priv.mret_wb     = (rand_bits(2) == 0);
    priv.if_valid_id = rand_bit();
    priv.mpp         = rand_lvl();
  endtask

  task automatic rand_bus();
    bus.instr_memtype = {rand_bit(), (rand_bits(2) == 0)};
    bus.data_req      = rand_bit();
    bus.data_we       = rand_bit();
    bus.data_memtype  = 2'(rand_bits(2));
    bus.data_atop     = (rand_bits(2) == 0) ? 6'(rand_bits(6)) : 6'd0;
  endtask

  // Offending probes are applied while reset is low so that every flag
  // would rise if a flop ignored the reset
  task automatic reset_dut();
    drive_quiet();
    rst_ni = 1'b0;
    model_reset();
    repeat (3) begin
      rand_wb();
      rand_trap();
      rand_ctrl();
      rand_priv();
      rand_bus();
      @(posedge clk);
      #1;
      check_violation(violation, '0);
    end
    drive_quiet();
    rst_ni = 1'b1;
  endtask

  // The caller drives inputs 1 ns after an edge and results are read 1 ns after the next
  task automatic apply_cycle(input bit per_field);
    model_step();
    @(posedge clk);
    #1;
    if (per_field) begin
      check_flag("mepc_mismatch", violation.mepc_mismatch, exp_viol.mepc_mismatch);
      check_flag("step_retire", violation.step_retire, exp_viol.step_retire);
      check_flag("priv_consistency", violation.priv_consistency, exp_viol.priv_consistency);
      check_flag("priv_to_user", violation.priv_to_user, exp_viol.priv_to_user);
      check_flag("priv_to_machine", violation.priv_to_machine, exp_viol.priv_to_machine);
      check_flag("trap_not_machine", violation.trap_not_machine, exp_viol.trap_not_machine);
      check_flag("mret_priv", violation.mret_priv, exp_viol.mret_priv);
      check_flag("bus_attr", violation.bus_attr, exp_viol.bus_attr);
    end else begin
      check_violation(violation, exp_viol);
    end
  endtask

  task automatic drive_priv(input monitor_cfg_pkg::priv_lvl_e lvl,
                            input monitor_cfg_pkg::priv_lvl_e lvl_if, input logic mret,
                            input monitor_cfg_pkg::priv_lvl_e mpp, input logic pc_set,
                            input monitor_cfg_pkg::pc_mux_e mux);
    drive_quiet();
    priv.priv_lvl    = lvl;
    priv.priv_lvl_if = lvl_if;
    priv.mret_id     = mret;
    priv.if_valid_id = mret;
    priv.mpp         = mpp;
    ctrl.pc_set      = pc_set;
    ctrl.pc_mux      = mux;
    apply_cycle(1'b1);
  endtask

  initial begin
    reset_dut();
    // Each round starts from reset so that first occurrences recur
    for (int r = 0; r < TRAP_ROUNDS; r++) begin
      reset_dut();
      for (int i = 0; i < ROUND_CYCLES; i++) begin
        rand_wb();
        rand_trap();
        apply_cycle(1'b1);
      end
    end
    for (int i = 0; i < STEP_CYCLES; i++) begin
      drive_quiet();
      wb.valid        = rand_bit();
      ctrl.step       = (rand_bits(2) != 0);
      ctrl.debug_mode = (rand_bits(2) == 0);
      apply_cycle(1'b1);
    end
    drive_priv(LVL_M, LVL_M, 1'b0, LVL_M, 1'b0, monitor_cfg_pkg::PC_BOOT);
    // Lawful MRET to user, then a lawful exception trap back to machine
    drive_priv(LVL_M, LVL_U, 1'b1, LVL_U, 1'b1, monitor_cfg_pkg::PC_MRET);
    drive_priv(LVL_U, LVL_M, 1'b0, LVL_U, 1'b1, monitor_cfg_pkg::PC_TRAP_EXC);
    // Drop to user with no MRET anywhere
    drive_priv(LVL_M, LVL_U, 1'b0, LVL_M, 1'b0, monitor_cfg_pkg::PC_BOOT);
    // MRET fetch level disagrees with mpp
    drive_priv(LVL_U, LVL_U, 1'b0, LVL_M, 1'b1, monitor_cfg_pkg::PC_MRET);
    drive_priv(LVL_M, LVL_M, 1'b0, LVL_M, 1'b0, monitor_cfg_pkg::PC_BOOT);
    drive_priv(LVL_M, LVL_M, 1'b0, LVL_M, 1'b0, monitor_cfg_pkg::PC_BOOT);
    for (int i = 0; i < PRIV_CYCLES; i++) begin
      rand_ctrl();
      rand_priv();
      apply_cycle(1'b1);
    end
    drive_quiet();
    for (int i = 0; i < BUS_CYCLES; i++) begin
      rand_bus();
      apply_cycle(1'b1);
    end
    reset_dut();
    for (int i = 0; i < MIX_CYCLES; i++) begin
      rand_wb();
      rand_trap();
      rand_ctrl();
      rand_priv();
      rand_bus();
      apply_cycle(1'b0);
    end
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Half again the nominal run length before giving up
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
